/* Bender.yml */
package:
  name: class_switch

export_include_dirs:
  - src

sources:
  - files:
      - src/switch_data_pkg.sv
      - src/switch_ctrl_pkg.sv
      - src/class_queue_if.sv
      - src/class_demux.sv
      - src/class_fifo.sv
      - src/class_flow_ctrl.sv
      - src/class_switch.sv
  - target: simulation
    files:
      - sim/tb_class_switch.sv

/* class_switch.f */
+incdir+src
src/switch_data_pkg.sv
src/switch_ctrl_pkg.sv
src/class_queue_if.sv
src/class_demux.sv
src/class_fifo.sv
src/class_flow_ctrl.sv
src/class_switch.sv
sim/tb_class_switch.sv

/* sim/tb_class_switch.sv */
// class switch testbench: scoreboard model per class checked by concurrent assertions

`timescale 1ns/10ps
`default_nettype none

`include "class_switch_cfg.svh"

module tb_class_switch;
  import switch_ctrl_pkg::*;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic [`CS_DATA_SIZE-1:0] in;
  logic                     valid_in, read0, read1;
  logic [`CS_DATA_SIZE-1:0] out0, out1;
  logic                     out0_valid, out1_valid, fifo0_empty, fifo1_empty;
  logic                     almost_full0, almost_full1, almost_empty0, almost_empty1;
  logic                     pause0, pause1, error0, error1;
  err_cause_e               err_cause0, err_cause1;
  integer                   seed;
  int                       t;
  logic [31:0]              r;
  string                    test_name;

  // scoreboard, one queue of expected words per class
  logic [`CS_DATA_SIZE-1:0] sb0 [$];
  logic [`CS_DATA_SIZE-1:0] sb1 [$];
  logic                     pend_v;  // word held in the demux stage
  logic [`CS_DATA_SIZE-1:0] pend_w;
  int                       exp_cnt   [2];
  logic                     exp_valid [2];
  logic [`CS_DATA_SIZE-1:0] exp_data  [2];
  logic                     exp_pause [2];
  err_cause_e               exp_cause [2];

  // DUT outputs regrouped by class index
  logic [1:0] act_valid, act_empty, act_ae, act_af, act_pause, act_err;
  logic [`CS_DATA_SIZE-1:0] act_data [2];
  err_cause_e act_cause [2];

  always #4 clk = ~clk;  // 8 ns period

  class_switch DUT (.*);

  assign act_valid = {out1_valid, out0_valid};
  assign act_empty = {fifo1_empty, fifo0_empty};
  assign act_ae    = {almost_empty1, almost_empty0};
  assign act_af    = {almost_full1, almost_full0};
  assign act_pause = {pause1, pause0};
  assign act_err   = {error1, error0};
  assign act_data[0] = out0;
  assign act_data[1] = out1;
  assign act_cause[0] = err_cause0;
  assign act_cause[1] = err_cause1;

  task automatic report_mismatch(string check, logic [15:0] expv, logic [15:0] actv);
    $display("MISMATCH test=%s check=%s expected=%0h actual=%0h", test_name, check, expv, actv);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic abort_run(string why);
    $display("ERROR in %s: %s", test_name, why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  // one clock edge of one class, from the occupancy seen before the edge
  task automatic step_class(int c, logic push, logic pop);
    int cnt;
    cnt = exp_cnt[c];
    exp_valid[c] = 1'b0;
    if (!exp_pause[c] && cnt >= `CS_ALMOST_FULL) exp_pause[c] = 1'b1;
    else if (exp_pause[c] && cnt <= `CS_ALMOST_EMPTY) exp_pause[c] = 1'b0;
    if (exp_cause[c] == ERR_NONE && push && cnt == `CS_FIFO_DEPTH) exp_cause[c] = ERR_OVERFLOW;
    else if (exp_cause[c] == ERR_NONE && pop && cnt == 0) exp_cause[c] = ERR_UNDERFLOW;
    if (pop && cnt > 0) begin
      exp_valid[c] = 1'b1;
      if (c == 0) exp_data[c] = sb0.pop_front();
      else exp_data[c] = sb1.pop_front();
    end
    if (push && cnt < `CS_FIFO_DEPTH) begin  // push into full queue is lost
      if (c == 0) sb0.push_back(pend_w);
      else sb1.push_back(pend_w);
    end
    exp_cnt[c] = (c == 0) ? sb0.size() : sb1.size();
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sb0.delete();
      sb1.delete();
      pend_v = 1'b0;
      pend_w = '0;
      for (int c = 0; c < 2; c++) begin
        exp_cnt[c] = 0;
        exp_valid[c] = 1'b0;
        exp_data[c] = '0;
        exp_pause[c] = 1'b0;
        exp_cause[c] = ERR_NONE;
      end
    end else begin
      step_class(0, pend_v && !pend_w[`CS_DATA_SIZE-1], read0);
      step_class(1, pend_v && pend_w[`CS_DATA_SIZE-1], read1);
      pend_v = valid_in;  // demux stage, pushed next edge
      pend_w = in;
    end
  end

  for (genvar i = 0; i < 2; i++) begin : g_chk
    a_valid: assert property (@(posedge clk) disable iff (!rst_n) act_valid[i] == exp_valid[i])
      else report_mismatch("out_valid", $sampled(exp_valid[i]), $sampled(act_valid[i]));
    a_data: assert property (@(posedge clk) disable iff (!rst_n)
      exp_valid[i] |-> act_data[i] == exp_data[i])
      else report_mismatch("out_data", $sampled(exp_data[i]), $sampled(act_data[i]));
    a_empty: assert property (@(posedge clk) disable iff (!rst_n)
      act_empty[i] == (exp_cnt[i] == 0))
      else report_mismatch("empty", $sampled(exp_cnt[i] == 0), $sampled(act_empty[i]));
    a_ae: assert property (@(posedge clk) disable iff (!rst_n)
      act_ae[i] == (exp_cnt[i] <= `CS_ALMOST_EMPTY))
      else report_mismatch("almost_empty", $sampled(exp_cnt[i] <= `CS_ALMOST_EMPTY),
                           $sampled(act_ae[i]));
    a_af: assert property (@(posedge clk) disable iff (!rst_n)
      act_af[i] == (exp_cnt[i] >= `CS_ALMOST_FULL))
      else report_mismatch("almost_full", $sampled(exp_cnt[i] >= `CS_ALMOST_FULL),
                           $sampled(act_af[i]));
    a_pause: assert property (@(posedge clk) disable iff (!rst_n) act_pause[i] == exp_pause[i])
      else report_mismatch("pause", $sampled(exp_pause[i]), $sampled(act_pause[i]));
    a_err: assert property (@(posedge clk) disable iff (!rst_n)
      act_err[i] == (exp_cause[i] != ERR_NONE))
      else report_mismatch("error", $sampled(exp_cause[i] != ERR_NONE), $sampled(act_err[i]));
    a_cause: assert property (@(posedge clk) disable iff (!rst_n) act_cause[i] == exp_cause[i])
      else report_mismatch("err_cause", $sampled(exp_cause[i]), $sampled(act_cause[i]));
  end

  task automatic drive(logic v, logic [`CS_DATA_SIZE-1:0] w, logic r0, logic r1);
    @(negedge clk);
    valid_in = v;
    in       = w;
    read0    = r0;
    read1    = r1;
  endtask

  // read every non-empty class until both queues are empty
  task automatic drain_queues();
    t = 0;
    while ((!fifo0_empty || !fifo1_empty) && t < 40) begin
      @(negedge clk);
      valid_in = 1'b0;
      read0 = !fifo0_empty;
      read1 = !fifo1_empty;
      t++;
    end
    if (!fifo0_empty || !fifo1_empty) abort_run("queues never drained");
    drive(1'b0, '0, 1'b0, 1'b0);
  endtask

  initial begin
    seed = 2;
    rst_n = 1'b0;
    valid_in = 1'b0;
    in = '0;
    read0 = 1'b0;
    read1 = 1'b0;
    test_name = "reset";
    repeat (2) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;
    repeat (3) drive(1'b0, '0, 1'b0, 1'b0);

    test_name = "routing";  // mixed pushes and reads, both classes
    repeat (60) begin
      @(negedge clk);
      r = $random(seed);
      valid_in = r[10] && !almost_full0 && !almost_full1;  // stays short of full
      in = r[`CS_DATA_SIZE-1:0];
      read0 = r[11] && !fifo0_empty;
      read1 = r[12] && !fifo1_empty;
    end
    repeat (2) drive(1'b0, '0, 1'b0, 1'b0);  // let words in flight land
    drain_queues();

    test_name = "pause_hysteresis";
    repeat (6) begin
      r = $random(seed);
      drive(1'b1, {1'b1, r[`CS_DATA_SIZE-2:0]}, 1'b0, 1'b0);
    end
    drive(1'b0, '0, 1'b0, 1'b0);
    t = 0;
    while (!pause1 && t < 10) begin
      drive(1'b0, '0, 1'b0, 1'b0);
      t++;
    end
    if (!pause1) abort_run("pause1 never rose at six words");
    repeat (3) drive(1'b0, '0, 1'b0, 1'b1);  // down to three, pause holds
    repeat (3) drive(1'b0, '0, 1'b0, 1'b0);
    drive(1'b0, '0, 1'b0, 1'b1);
    t = 0;
    while (pause1 && t < 10) begin
      drive(1'b0, '0, 1'b0, 1'b0);
      t++;
    end
    if (pause1) abort_run("pause1 never fell at two words");
    drain_queues();

    test_name = "overflow";  // ninth word into class 0 is lost
    repeat (9) begin
      r = $random(seed);
      drive(1'b1, {1'b0, r[`CS_DATA_SIZE-2:0]}, 1'b0, 1'b0);
    end
    drive(1'b0, '0, 1'b0, 1'b0);
    t = 0;
    while (!error0 && t < 10) begin
      drive(1'b0, '0, 1'b0, 1'b0);
      t++;
    end
    if (!error0) abort_run("error0 never set on overflow");
    drain_queues();

    test_name = "underflow";
    drive(1'b0, '0, 1'b0, 1'b1);  // class 1 already empty
    drive(1'b0, '0, 1'b0, 1'b0);
    t = 0;
    while (!error1 && t < 10) begin
      drive(1'b0, '0, 1'b0, 1'b0);
      t++;
    end
    if (!error1) abort_run("error1 never set on underflow");
    repeat (4) drive(1'b0, '0, 1'b0, 1'b0);

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* src/class_demux.sv */
// class demux: registers incoming words and steers each one to its class queue

`timescale 1ns/10ps
`default_nettype none

module class_demux (
  input  logic                      clk,
  input  logic                      rst_n,
  input  switch_data_pkg::sw_word_t in,
  input  logic                      valid_in,
  class_queue_if.producer           q0,
  class_queue_if.producer           q1
);
  import switch_data_pkg::*;

  sw_word_t  word_q;   // registered input word
  logic      valid_q;  // registered strobe
  sw_class_e cls;

  // payload only loads on a valid word
  always_ff @(posedge clk) begin
    if (valid_in) begin
      word_q <= in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_in;
    end
  end

  assign cls = word_class(word_q);

  // one push per registered word, picked by the class bit
  assign q0.push      = valid_q && (cls == CLASS_0);
  assign q1.push      = valid_q && (cls == CLASS_1);
  assign q0.push_data = word_q;  // both queues see the same data
  assign q1.push_data = word_q;

  // each accepted word lands in exactly one queue on the next cycle
  a_one_push: assert property (@(posedge clk) disable iff (!rst_n)
    valid_in |=> $onehot({q0.push, q1.push}));

endmodule

`default_nettype wire

/* src/class_fifo.sv */
// class fifo holding one class of words, with occupancy count and status flags

`timescale 1ns/10ps
`default_nettype none

`include "class_switch_cfg.svh"

module class_fifo (
  input  logic         clk,
  input  logic         rst_n,
  class_queue_if.queue q
);
  import switch_data_pkg::*;

  localparam int DEPTH = `CS_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);  // must hold DEPTH itself

  sw_word_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;  // current occupancy
  logic             do_push;
  logic             do_pop;

  // pointer step with wrap at DEPTH
  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign do_push = q.push && !q.full;   // word dropped when full
  assign do_pop  = q.pop && !q.empty;   // read ignored when empty

  // storage write
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= q.push_data;
    end
  end

  // head word out one cycle after the pop edge
  always_ff @(posedge clk) begin
    if (do_pop) begin
      q.pop_data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      q.pop_valid <= 1'b0;
    end else begin
      q.pop_valid <= do_pop;
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // push and pop together leave count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // flags straight off the count register
  assign q.empty        = (count == '0);
  assign q.full         = (count == CNT_W'(DEPTH));
  assign q.almost_full  = (count >= CNT_W'(`CS_ALMOST_FULL));
  assign q.almost_empty = (count <= CNT_W'(`CS_ALMOST_EMPTY));

  a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
    count <= CNT_W'(DEPTH));

  // pointers meet only when the queue is empty or full
  a_empty_full: assert property (@(posedge clk) disable iff (!rst_n)
    (q.empty || q.full) == (wr_ptr == rd_ptr));

endmodule

`default_nettype wire

/* src/class_flow_ctrl.sv */
// flow controller with pause hysteresis and sticky overflow and underflow flags per class

`timescale 1ns/10ps
`default_nettype none

module class_flow_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  class_queue_if.monitor              q0,
  class_queue_if.monitor              q1,
  output logic                        pause0,
  output logic                        pause1,
  output logic                        error0,
  output logic                        error1,
  output switch_ctrl_pkg::err_cause_e err_cause0,
  output switch_ctrl_pkg::err_cause_e err_cause1
);
  import switch_ctrl_pkg::*;

  // flags of both classes packed by class index
  logic [1:0]  push_v;
  logic [1:0]  pop_v;
  logic [1:0]  full_v;
  logic [1:0]  empty_v;
  logic [1:0]  af_v;
  logic [1:0]  ae_v;
  flow_state_e state_q [2];
  logic        err_q   [2];
  err_cause_e  cause_q [2];

  assign push_v  = {q1.push, q0.push};
  assign pop_v   = {q1.pop, q0.pop};
  assign full_v  = {q1.full, q0.full};
  assign empty_v = {q1.empty, q0.empty};
  assign af_v    = {q1.almost_full, q0.almost_full};
  assign ae_v    = {q1.almost_empty, q0.almost_empty};

  for (genvar i = 0; i < 2; i++) begin : g_class
    logic ovf;  // push while full
    logic udf;  // pop while empty

    assign ovf = push_v[i] && full_v[i];
    assign udf = pop_v[i] && empty_v[i];

    // enter pause on almost_full and leave only on almost_empty
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        state_q[i] <= FLOW_RUN;
      end else if (state_q[i] == FLOW_RUN && af_v[i]) begin
        state_q[i] <= FLOW_PAUSE;
      end else if (state_q[i] == FLOW_PAUSE && ae_v[i]) begin
        state_q[i] <= FLOW_RUN;
      end
    end

    // first cause wins and the flag sticks until reset
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        err_q[i]   <= 1'b0;
        cause_q[i] <= ERR_NONE;
      end else if (!err_q[i] && (ovf || udf)) begin
        err_q[i]   <= 1'b1;
        cause_q[i] <= ovf ? ERR_OVERFLOW : ERR_UNDERFLOW;
      end
    end

    // pause rises only on a queue that is almost full and not almost empty
    a_pause_rise: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(state_q[i] == FLOW_PAUSE) |-> $past(af_v[i] && !ae_v[i]));
  end

  assign pause0     = (state_q[0] == FLOW_PAUSE);
  assign pause1     = (state_q[1] == FLOW_PAUSE);
  assign error0     = err_q[0];
  assign error1     = err_q[1];
  assign err_cause0 = cause_q[0];
  assign err_cause1 = cause_q[1];

endmodule

`default_nettype wire

/* src/class_queue_if.sv */
// class queue interface: push, pop and status signals of one class queue

`timescale 1ns/10ps
`default_nettype none

interface class_queue_if;
  import switch_data_pkg::*;

  logic     push;          // one word per high cycle
  sw_word_t push_data;
  logic     pop;           // read strobe from downstream
  sw_word_t pop_data;      // head word, registered
  logic     pop_valid;     // pop_data good this cycle
  logic     empty;
  logic     full;
  logic     almost_full;
  logic     almost_empty;

  // demux side
  modport producer (output push, push_data);

  // storage side
  modport queue (
    input  push, push_data, pop,
    output pop_data, pop_valid, empty, full, almost_full, almost_empty
  );

  // controller watches strobes and status only
  modport monitor (input push, pop, full, empty, almost_full, almost_empty);

endinterface

`default_nettype wire

/* src/class_switch.sv */
// class switch top: demux into two class queues with flow and error control

`timescale 1ns/10ps
`default_nettype none

`include "class_switch_cfg.svh"

module class_switch (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`CS_DATA_SIZE-1:0]    in,
  input  logic                        valid_in,
  input  logic                        read0,       // pop class 0
  input  logic                        read1,       // pop class 1
  output logic [`CS_DATA_SIZE-1:0]    out0,
  output logic [`CS_DATA_SIZE-1:0]    out1,
  output logic                        out0_valid,
  output logic                        out1_valid,
  output logic                        fifo0_empty,
  output logic                        fifo1_empty,
  output logic                        almost_full0,
  output logic                        almost_full1,
  output logic                        almost_empty0,
  output logic                        almost_empty1,
  output logic                        pause0,      // advisory to upstream
  output logic                        pause1,
  output logic                        error0,      // sticky
  output logic                        error1,
  output switch_ctrl_pkg::err_cause_e err_cause0,
  output switch_ctrl_pkg::err_cause_e err_cause1
);

  class_queue_if q0_if ();  // class 0 queue bundle
  class_queue_if q1_if ();  // class 1 queue bundle

  // reads come straight from downstream
  assign q0_if.pop = read0;
  assign q1_if.pop = read1;

  class_demux u_demux (
    .clk      (clk),
    .rst_n    (rst_n),
    .in       (in),
    .valid_in (valid_in),
    .q0       (q0_if),
    .q1       (q1_if)
  );

  class_fifo u_fifo0 (.clk(clk), .rst_n(rst_n), .q(q0_if));
  class_fifo u_fifo1 (.clk(clk), .rst_n(rst_n), .q(q1_if));

  class_flow_ctrl u_flow_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .q0         (q0_if),
    .q1         (q1_if),
    .pause0     (pause0),
    .pause1     (pause1),
    .error0     (error0),
    .error1     (error1),
    .err_cause0 (err_cause0),
    .err_cause1 (err_cause1)
  );

  // queue outputs to pins
  assign out0          = q0_if.pop_data;
  assign out1          = q1_if.pop_data;
  assign out0_valid    = q0_if.pop_valid;
  assign out1_valid    = q1_if.pop_valid;
  assign fifo0_empty   = q0_if.empty;
  assign fifo1_empty   = q1_if.empty;
  assign almost_full0  = q0_if.almost_full;
  assign almost_full1  = q1_if.almost_full;
  assign almost_empty0 = q0_if.almost_empty;
  assign almost_empty1 = q1_if.almost_empty;

endmodule

`default_nettype wire

/* src/class_switch_cfg.svh */
// class switch config: word width, queue depth and status thresholds

`ifndef CLASS_SWITCH_CFG_SVH
`define CLASS_SWITCH_CFG_SVH

// word width, top bit carries the traffic class
`define CS_DATA_SIZE 10

// entries per class queue
`define CS_FIFO_DEPTH 8

// almost_full high at or above this occupancy
`define CS_ALMOST_FULL 6

// almost_empty high at or below this occupancy
`define CS_ALMOST_EMPTY 2

`endif

/* src/switch_ctrl_pkg.sv */
// switch control package: per class flow state and error cause encodings

`default_nettype none

package switch_ctrl_pkg;

  // pause hysteresis state, one per class
  typedef enum logic {
    FLOW_RUN   = 1'b0,
    FLOW_PAUSE = 1'b1
  } flow_state_e;

  // first error seen on a class, held until reset
  typedef enum logic [1:0] {
    ERR_NONE      = 2'b00,
    ERR_OVERFLOW  = 2'b01,  // push into full queue
    ERR_UNDERFLOW = 2'b10   // pop from empty queue
  } err_cause_e;

endpackage

`default_nettype wire

/* src/switch_data_pkg.sv */
// switch data package: word format and traffic class decode for the data path

`default_nettype none

package switch_data_pkg;

  `include "class_switch_cfg.svh"

  localparam int CLASS_BIT = `CS_DATA_SIZE - 1;  // msb selects the class

  typedef logic [`CS_DATA_SIZE-1:0] sw_word_t;

  typedef enum logic {
    CLASS_0 = 1'b0,
    CLASS_1 = 1'b1
  } sw_class_e;

  // class of a word, straight from its top bit
  function automatic sw_class_e word_class(sw_word_t w);
    return sw_class_e'(w[CLASS_BIT]);
  endfunction

endpackage

`default_nettype wire
